// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := divSqrtUnitTb
FILELIST := divSqrtUnit.f
OBJDIR   := obj_dir
PASSMSG  := Verification passed

.PHONY: sim clean

# Pass only when the pass message shows up in the simulation output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: divSqrtUnit.f
src/arithPkg.sv
src/ctrlPkg.sv
src/divSqrtPreproc.sv
src/divSqrtFsm.sv
src/divSqrtIter.sv
src/divSqrtPostproc.sv
src/divSqrtUnit.sv
tb/divSqrtUnitTb.sv

// File: src/arithPkg.sv
// Unsigned 16-bit operands only; no signed, floating-point or rounding support
`default_nettype none

package arithPkg;

  ////////////////////
  // Widths
  ////////////////////

  // One data word, shared by operands and results
  localparam int dataWidth = 16;

  ////////////////////
  // Operation codes
  ////////////////////

  // Single-bit operation select
  localparam logic opDiv  = 1'b0;
  localparam logic opSqrt = 1'b1;

  ////////////////////
  // Request and result
  ////////////////////

  // Request word, sampled when a start is accepted
  // b is ignored for square root
  typedef struct packed {
    logic                 op;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
  } divSqrtReq_t;

  // Result word, valid while done is high
  // For square root q is the root and r is a minus root squared
  typedef struct packed {
    logic [dataWidth-1:0] q;
    logic [dataWidth-1:0] r;
    logic                 divByZero;
  } divSqrtRes_t;

endpackage

`default_nettype wire

// File: src/ctrlPkg.sv
// Step counter sized for at most 16 steps; operand fields follow arithPkg data width
`default_nettype none

package ctrlPkg;

  ////////////////////
  // Control encodings
  ////////////////////

  // Up to 16 steps, plus zero
  localparam int stepWidth = 5;

  // Control FSM states
  typedef enum logic [1:0] {
    stIdle,
    stBusy,
    stDone
  } ctrlState_t;

  ////////////////////
  // Preprocessed operands
  ////////////////////

  // aligned is a shifted left past its leading zeros
  // steps is the loop count left after alignment
  typedef struct packed {
    logic                           op;
    logic [arithPkg::dataWidth-1:0] aligned;
    logic [arithPkg::dataWidth-1:0] divisor;
    logic [arithPkg::dataWidth-1:0] origA;
    logic [stepWidth-1:0]           steps;
    logic                           special;
    logic                           divByZero;
  } prepOps_t;

endpackage

`default_nettype wire

// File: src/divSqrtFsm.sv
// Start is taken only in idle without stall; flush and reset win over every other event
`timescale 1ns/1ps
`default_nettype none

module divSqrtFsm (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          start,
  input  wire logic                          stall,
  input  wire logic                          flush,
  input  wire logic [ctrlPkg::stepWidth-1:0] steps,
  input  wire logic                          special,
  input  wire logic                          zeroRes,
  output logic                               accepted,
  output logic                               busy,
  output logic                               done,
  output logic                               iterEn,
  output logic [ctrlPkg::stepWidth-1:0]      remSteps
);

  ctrlPkg::ctrlState_t               state;
  logic [ctrlPkg::stepWidth-1:0]     stepCnt;

  ////////////////////
  // Outputs
  ////////////////////

  // Take a start only while idle and not held back
  assign accepted = start && (state == ctrlPkg::stIdle) && !stall;
  // Busy already in the accepting cycle
  assign busy     = (state == ctrlPkg::stBusy) || accepted;
  assign done     = (state == ctrlPkg::stDone);
  // One iteration per busy cycle
  assign iterEn   = (state == ctrlPkg::stBusy);
  // Steps not yet run, used to realign after an early stop
  assign remSteps = stepCnt;

  ////////////////////
  // State and step count
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state   <= ctrlPkg::stIdle;
      stepCnt <= '0;
    end else if (accepted) begin
      stepCnt <= steps;
      // Special operands need no loop
      if (special) begin
        state <= ctrlPkg::stDone;
      end else begin
        state <= ctrlPkg::stBusy;
      end
    end else if (state == ctrlPkg::stBusy) begin
      stepCnt <= stepCnt - 1'b1;
      // Last step, or nothing left that could change the result
      if (stepCnt == 1 || zeroRes) begin
        state <= ctrlPkg::stDone;
      end
    end else if (state == ctrlPkg::stDone) begin
      // Hold the result while the consumer stalls
      if (!stall) begin
        state <= ctrlPkg::stIdle;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // An accepted start came from idle and moves on at the next edge
  acceptFromIdle: assert property (
    @(posedge clk) disable iff (rst)
    accepted && !flush |=> $past(state) == ctrlPkg::stIdle && state != ctrlPkg::stIdle
  );

  // The busy output, accepting cycle included, never overlaps done
  doneNotBusy: assert property (
    @(posedge clk) disable iff (rst)
    !(done && busy)
  );

  // The count loaded at acceptance runs out no later than the busy state
  noStepUnderflow: assert property (
    @(posedge clk) disable iff (rst)
    iterEn |-> remSteps != '0
  );

endmodule

`default_nettype wire

// File: src/divSqrtIter.sv
// One radix-2 step per enabled cycle; operands must be prealigned and nonzero
`timescale 1ns/1ps
`default_nettype none

module divSqrtIter (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             load,
  input  wire logic                             iterEn,
  input  wire ctrlPkg::prepOps_t                prep,
  output logic [arithPkg::dataWidth-1:0]        rawQ,
  output logic [arithPkg::dataWidth-1:0]        rawR,
  output logic                                  zeroRes
);

  localparam int w = arithPkg::dataWidth;

  logic           sqrtMode;
  logic [w-1:0]   divisorReg;
  // Operand bits not yet consumed, MSB first
  logic [w-1:0]   opReg;
  logic [w-1:0]   qReg;
  // One spare bit for the trial subtraction
  logic [w:0]     remReg;
  logic [w:0]     remShift;
  logic [w:0]     trial;
  logic [w:0]     diff;
  logic [w:0]     remNext;
  logic [w-1:0]   opNext;
  logic [w-1:0]   qNext;
  logic           fits;

  ////////////////////
  // Step datapath
  ////////////////////

  always_comb begin
    if (sqrtMode) begin
      // Bring down the next bit pair
      remShift = {remReg[w-2:0], opReg[w-1 -: 2]};
      // Four times the partial root plus one
      trial    = {qReg[w-2:0], 2'b01};
      opNext   = {opReg[w-3:0], 2'b00};
    end else begin
      // Bring down the next dividend bit
      remShift = {remReg[w-1:0], opReg[w-1]};
      trial    = {1'b0, divisorReg};
      opNext   = {opReg[w-2:0], 1'b0};
    end
    diff    = remShift - trial;
    // Restoring: keep the difference only if it stays non-negative
    fits    = (remShift >= trial);
    remNext = fits ? diff : remShift;
    qNext   = {qReg[w-2:0], fits};
  end

  ////////////////////
  // Registers
  ////////////////////

  // Mode and residual
  always_ff @(posedge clk) begin
    if (rst) begin
      sqrtMode <= 1'b0;
      remReg   <= '0;
    end else if (load) begin
      sqrtMode <= (prep.op == arithPkg::opSqrt);
      remReg   <= '0;
    end else if (iterEn) begin
      remReg <= remNext;
    end
  end

  // Operand shifter and quotient
  always_ff @(posedge clk) begin
    if (load) begin
      opReg      <= prep.aligned;
      divisorReg <= prep.divisor;
      qReg       <= '0;
    end else if (iterEn) begin
      opReg <= opNext;
      qReg  <= qNext;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign rawQ    = qReg;
  // Residual never exceeds one word for either operation
  assign rawR    = remReg[w-1:0];
  // Remaining steps would only append zero quotient bits
  assign zeroRes = (remReg == '0) && (opReg == '0);

  // A new operand never arrives mid-loop
  noLoadWhileIter: assert property (
    @(posedge clk) disable iff (rst)
    !(load && iterEn)
  );

endmodule

`default_nettype wire

// File: src/divSqrtPostproc.sv
// Result is combinational from iterator state; valid only while done is high
`timescale 1ns/1ps
`default_nettype none

module divSqrtPostproc (
  input  wire logic                                 clk,
  input  wire logic                                 rst,
  input  wire logic                                 capture,
  input  wire ctrlPkg::prepOps_t                    prep,
  input  wire logic [arithPkg::dataWidth-1:0]       rawQ,
  input  wire logic [arithPkg::dataWidth-1:0]       rawR,
  input  wire logic [ctrlPkg::stepWidth-1:0]        remSteps,
  input  wire logic                                 special,
  output arithPkg::divSqrtRes_t                     res
);

  logic                           specialReg;
  logic                           dbzReg;
  logic [arithPkg::dataWidth-1:0] origAReg;

  ////////////////////
  // Capture at acceptance
  ////////////////////

  // Flags
  always_ff @(posedge clk) begin
    if (rst) begin
      specialReg <= 1'b0;
      dbzReg     <= 1'b0;
    end else if (capture) begin
      specialReg <= special;
      dbzReg     <= prep.divByZero;
    end
  end

  // Dividend, the remainder of a zero divide
  always_ff @(posedge clk) begin
    if (capture) begin
      origAReg <= prep.origA;
    end
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    res.divByZero = dbzReg;
    if (dbzReg) begin
      // RISC-V rule: all ones, remainder is the dividend
      res.q = '1;
      res.r = origAReg;
    end else if (specialReg) begin
      // Zero operand, nothing to compute
      res.q = '0;
      res.r = '0;
    end else if (remSteps != '0) begin
      // Early stop: skipped steps were zero bits, residual was zero
      res.q = rawQ << remSteps;
      res.r = '0;
    end else begin
      res.q = rawQ;
      res.r = rawR;
    end
  end

endmodule

`default_nettype wire

// File: src/divSqrtPreproc.sv
// Purely combinational; steps is meaningless when special is set
`timescale 1ns/1ps
`default_nettype none

module divSqrtPreproc (
  input  wire arithPkg::divSqrtReq_t req,
  output ctrlPkg::prepOps_t          prep
);

  logic [ctrlPkg::stepWidth-1:0] lz;
  logic [ctrlPkg::stepWidth-1:0] lzEven;
  logic [ctrlPkg::stepWidth-1:0] shAmt;
  logic                          isSqrt;
  logic                          aZero;
  logic                          bZero;

  ////////////////////
  // Leading zeros
  ////////////////////

  // Highest set bit wins, a zero operand counts the full width
  always_comb begin
    lz = ctrlPkg::stepWidth'(arithPkg::dataWidth);
    for (int i = 0; i < arithPkg::dataWidth; i++) begin
      if (req.a[i]) begin
        lz = ctrlPkg::stepWidth'(arithPkg::dataWidth - 1 - i);
      end
    end
  end

  // Square root consumes bit pairs, so skip whole pairs only
  assign lzEven = {lz[ctrlPkg::stepWidth-1:1], 1'b0};

  assign isSqrt = (req.op == arithPkg::opSqrt);
  assign shAmt  = isSqrt ? lzEven : lz;

  ////////////////////
  // Special operands
  ////////////////////

  assign aZero = (req.a == '0);
  // Divisor only matters for division
  assign bZero = !isSqrt && (req.b == '0);

  ////////////////////
  // Packed result
  ////////////////////

  always_comb begin
    prep.op      = req.op;
    // First operand bit lands at the MSB
    prep.aligned = req.a << shAmt;
    prep.divisor = req.b;
    prep.origA   = req.a;
    // One bit per division step, two per root step
    if (isSqrt) begin
      prep.steps = (ctrlPkg::stepWidth'(arithPkg::dataWidth) - lzEven) >> 1;
    end else begin
      prep.steps = ctrlPkg::stepWidth'(arithPkg::dataWidth) - lz;
    end
    prep.special   = aZero || bZero;
    prep.divByZero = bZero;
  end

endmodule

`default_nettype wire

// File: src/divSqrtUnit.sv
// Strobe and level interface without handshake; res is valid only while done is high
`timescale 1ns/1ps
`default_nettype none

module divSqrtUnit (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start,
  input  wire logic                  stall,
  input  wire logic                  flush,
  input  wire arithPkg::divSqrtReq_t req,
  output logic                       accepted,
  output logic                       busy,
  output logic                       done,
  output arithPkg::divSqrtRes_t      res
);

  ctrlPkg::prepOps_t                 prep;
  logic                              iterEn;
  logic                              zeroRes;
  logic [ctrlPkg::stepWidth-1:0]     remSteps;
  logic [arithPkg::dataWidth-1:0]    rawQ;
  logic [arithPkg::dataWidth-1:0]    rawR;

  ////////////////////
  // Front end
  ////////////////////

  divSqrtPreproc u_preproc (
    .req  (req),
    .prep (prep)
  );

  // Control
  divSqrtFsm u_fsm (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .stall    (stall),
    .flush    (flush),
    .steps    (prep.steps),
    .special  (prep.special),
    .zeroRes  (zeroRes),
    .accepted (accepted),
    .busy     (busy),
    .done     (done),
    .iterEn   (iterEn),
    .remSteps (remSteps)
  );

  ////////////////////
  // Datapath
  ////////////////////

  // Loaded by the accepted strobe
  divSqrtIter u_iter (
    .clk     (clk),
    .rst     (rst),
    .load    (accepted),
    .iterEn  (iterEn),
    .prep    (prep),
    .rawQ    (rawQ),
    .rawR    (rawR),
    .zeroRes (zeroRes)
  );

  divSqrtPostproc u_postproc (
    .clk      (clk),
    .rst      (rst),
    .capture  (accepted),
    .prep     (prep),
    .rawQ     (rawQ),
    .rawR     (rawR),
    .remSteps (remSteps),
    .special  (prep.special),
    .res      (res)
  );

endmodule

`default_nettype wire

// File: tb/divSqrtUnitTb.sv
// Self-checking testbench; stops at the first failed assertion and bounds every wait to 40 cycles
`timescale 1ns/1ps
`default_nettype none

module divSqrtUnitTb;

  localparam int w = arithPkg::dataWidth;
  localparam int waitLimit = 40;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic                  stall;
  logic                  flush;
  arithPkg::divSqrtReq_t req;
  logic                  accepted;
  logic                  busy;
  logic                  done;
  arithPkg::divSqrtRes_t res;

  // Reference results for the operation in flight
  logic [w-1:0] expQ;
  logic [w-1:0] expR;
  logic         expDbz;
  logic         expSpecial;
  int           expSteps;
  // Edges counted from the accepting edge
  int           edgeCnt;
  logic [31:0]  lfsrState;
  logic [31:0]  opBit;
  logic [w-1:0] opA;
  logic [w-1:0] opB;

  divSqrtUnit u_dut (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .stall    (stall),
    .flush    (flush),
    .req      (req),
    .accepted (accepted),
    .busy     (busy),
    .done     (done),
    .res      (res)
  );

  always #5 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic reportError(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // Random width as well as random value
  task automatic randOperand(output logic [w-1:0] v);
    logic [31:0] raw;
    logic [31:0] sh;
    drawBits(w, raw);
    drawBits(4, sh);
    v = raw[w-1:0] >> sh[3:0];
  endtask

  function automatic int leadingZeros(input logic [w-1:0] v);
    int   n;
    logic found;
    n = 0;
    found = 1'b0;
    for (int i = w - 1; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n++;
      end
    end
    return n;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  task automatic computeExpected(input logic op, input logic [w-1:0] a, input logic [w-1:0] b);
    int lz;
    int root;
    int aInt;
    lz = leadingZeros(a);
    aInt = int'(a);
    expDbz = (op == arithPkg::opDiv) && (b == '0);
    expSpecial = expDbz || (a == '0);
    if (expDbz) begin
      // RISC-V divide by zero
      expQ = '1;
      expR = a;
    end else if (a == '0) begin
      expQ = '0;
      expR = '0;
    end else if (op == arithPkg::opDiv) begin
      expQ = a / b;
      expR = a % b;
    end else begin
      root = 0;
      while ((root + 1) * (root + 1) <= aInt) begin
        root++;
      end
      expQ = root[w-1:0];
      expR = w'(aInt - root * root);
    end
    // One step per bit after the skipped zeros and one per pair for the root
    if (op == arithPkg::opDiv) begin
      expSteps = w - lz;
    end else begin
      expSteps = (w - (lz - lz % 2)) / 2;
    end
  endtask

  ////////////////////
  // Handshake waits
  ////////////////////

  // Returns one ns after the accepting edge
  task automatic waitAccept();
    int   cnt;
    logic seen;
    cnt = 0;
    seen = 1'b0;
    while (!seen && cnt < waitLimit) begin
      @(negedge clk);
      seen = accepted;
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!seen) begin
      reportError("timeout: start was never accepted");
    end
  endtask

  // Returns one ns after the first edge that sees done
  task automatic waitDone();
    int   cnt;
    logic seen;
    cnt = 0;
    seen = 1'b0;
    while (!seen && cnt < waitLimit) begin
      @(negedge clk);
      seen = done;
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!seen) begin
      reportError("timeout: done never rose");
    end
  endtask

  task automatic runOp(input logic op, input logic [w-1:0] a, input logic [w-1:0] b);
    computeExpected(op, a, b);
    req.op = op;
    req.a  = a;
    req.b  = b;
    start  = 1'b1;
    waitAccept();
    start = 1'b0;
    waitDone();
  endtask

  ////////////////////
  // Checks
  ////////////////////

  always @(posedge clk) begin
    if (rst) begin
      edgeCnt <= 0;
    end else if (accepted) begin
      edgeCnt <= 1;
    end else if (!done && edgeCnt != 0) begin
      edgeCnt <= edgeCnt + 1;
    end
  end

  resultCheck: assert property (
    @(posedge clk) disable iff (rst)
    $rose(done) |-> res.q == expQ && res.r == expR && res.divByZero == expDbz
  ) else reportError($sformatf("mismatch at %0t: got q=%h r=%h dbz=%b, expected q=%h r=%h dbz=%b",
    $time, $sampled(res.q), $sampled(res.r), $sampled(res.divByZero), expQ, expR, expDbz));

  // Special cases take one edge and loops at most steps plus one
  latencyCheck: assert property (
    @(posedge clk) disable iff (rst)
    $rose(done) |-> (expSpecial ? edgeCnt == 1 : edgeCnt <= expSteps + 1)
  ) else reportError($sformatf("mismatch at %0t: latency %0d edges, steps %0d, special %b",
    $time, $sampled(edgeCnt), expSteps, expSpecial));

  stallHold: assert property (
    @(posedge clk) disable iff (rst)
    done && stall && !flush |=> done && $stable(res)
  ) else reportError("done or result changed while stalled");

  noAcceptInDone: assert property (
    @(posedge clk) disable iff (rst)
    done && start |-> !accepted
  ) else reportError("start accepted while done was high");

  noAcceptUnderStall: assert property (
    @(posedge clk) disable iff (rst)
    stall && start |-> !accepted
  ) else reportError("start accepted while stall was high");

  noAcceptWhileBusy: assert property (
    @(posedge clk) disable iff (rst)
    start && $past(busy) && !$past(flush) |-> !accepted
  ) else reportError("start accepted while an operation was running");

  busyWithAccept: assert property (
    @(posedge clk) disable iff (rst)
    accepted |-> busy
  ) else reportError("busy was low in the accepting cycle");

  // After a busy cycle exactly one of busy and done is high
  busyUntilDone: assert property (
    @(posedge clk) disable iff (rst)
    busy && !flush |=> busy != done
  ) else reportError("busy and done out of step after a busy cycle");

  flushToIdle: assert property (
    @(posedge clk) disable iff (rst)
    flush |=> !busy && !done
  ) else reportError("busy or done still high after flush");

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    req = '0;
    lfsrState = 32'hef30_6300;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // Special operands
    runOp(arithPkg::opDiv, 16'h1234, 16'h0000);
    runOp(arithPkg::opDiv, 16'h0000, 16'h0000);
    runOp(arithPkg::opDiv, 16'h0000, 16'h0005);
    runOp(arithPkg::opSqrt, 16'h0000, 16'h0000);

    // Boundaries and early termination on powers of two
    runOp(arithPkg::opDiv, 16'hffff, 16'h0001);
    runOp(arithPkg::opDiv, 16'h0001, 16'hffff);
    runOp(arithPkg::opDiv, 16'h0100, 16'h0010);
    runOp(arithPkg::opSqrt, 16'hffff, 16'h0000);
    runOp(arithPkg::opSqrt, 16'h0001, 16'h0000);
    runOp(arithPkg::opSqrt, 16'h0400, 16'h0000);
    runOp(arithPkg::opSqrt, 16'h4000, 16'h0000);

    for (int i = 0; i < 80; i++) begin
      drawBits(1, opBit);
      randOperand(opA);
      randOperand(opB);
      // Zero divisors are covered above
      if (opB == '0) begin
        opB = 16'h0001;
      end
      runOp(opBit[0], opA, opB);
    end

    // Start while busy and stall over done with start held
    computeExpected(arithPkg::opDiv, 16'hffff, 16'h0007);
    req.op = arithPkg::opDiv;
    req.a  = 16'hffff;
    req.b  = 16'h0007;
    start  = 1'b1;
    waitAccept();
    @(posedge clk);
    #1;
    stall = 1'b1;
    waitDone();
    repeat (3) @(posedge clk);
    #1;
    // Start still high as stall drops is taken only after done ends
    stall = 1'b0;
    waitAccept();
    start = 1'b0;
    waitDone();

    // Stall raised in idle holds a start back until it drops
    computeExpected(arithPkg::opSqrt, 16'h9c40, 16'h0000);
    req.op = arithPkg::opSqrt;
    req.a  = 16'h9c40;
    req.b  = 16'h0000;
    stall  = 1'b1;
    start  = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    stall = 1'b0;
    waitAccept();
    start = 1'b0;
    waitDone();

    // Flush mid-loop and a clean restart
    computeExpected(arithPkg::opDiv, 16'hffff, 16'h0003);
    req.op = arithPkg::opDiv;
    req.a  = 16'hffff;
    req.b  = 16'h0003;
    start  = 1'b1;
    waitAccept();
    start = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(posedge clk);
    #1;
    runOp(arithPkg::opDiv, 16'd1000, 16'd7);
    runOp(arithPkg::opSqrt, 16'd1000, 16'd0);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
